/* hw/framebuffer.sv */
`timescale 1ns/1ps
`default_nettype none

module framebuffer #(
  parameter int screen_width  = 16,
  parameter int screen_height = 4,
  localparam int num_pixels = screen_width * screen_height,
  localparam int addr_w = (num_pixels > 1) ? $clog2(num_pixels) : 1,
  localparam int x_w = (screen_width > 1) ? $clog2(screen_width) : 1,
  localparam int y_w = (screen_height > 1) ? $clog2(screen_height) : 1
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              dot_en,
  input  logic              flush,
  input  logic [7:0]        scx,
  input  logic              shade_valid,
  input  ppu_pkg::shade_t   shade,
  output logic              shade_ready,
  output logic              frame_done,
  input  logic [addr_w-1:0] rd_addr,
  output ppu_pkg::shade_t   rd_shade
);

  ppu_pkg::shade_t mem [num_pixels];

  logic [x_w-1:0]    x_pos;
  logic [y_w-1:0]    y_pos;
  logic              line_open;
  logic [2:0]        discard_left;
  logic              consume;
  logic              discard;
  logic              do_write;
  logic [addr_w-1:0] wr_addr;

  // Dot enable stands in for the drawing mode
  assign shade_ready = dot_en;
  assign consume     = shade_valid && dot_en;

  // First pixel of a line samples the fine scroll directly
  assign discard  = line_open ? (discard_left != 3'd0) : (scx[2:0] != 3'd0);
  assign do_write = consume && !discard && !flush;
  assign wr_addr  = addr_w'(int'(y_pos) * screen_width + int'(x_pos));

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      x_pos        <= '0;
      y_pos        <= '0;
      line_open    <= 1'b0;
      discard_left <= 3'd0;
      frame_done   <= 1'b0;
    end else if (flush) begin
      x_pos        <= '0;
      y_pos        <= '0;
      line_open    <= 1'b0;
      discard_left <= 3'd0;
      frame_done   <= 1'b0;
    end else if (consume) begin
      if (!line_open) begin
        line_open    <= 1'b1;
        discard_left <= (scx[2:0] != 3'd0) ? scx[2:0] - 3'd1 : 3'd0;
      end else if (discard) begin
        discard_left <= discard_left - 3'd1;
      end
      if (do_write) begin
        if (x_pos == x_w'(screen_width - 1)) begin
          x_pos     <= '0;
          line_open <= 1'b0;
          if (y_pos == y_w'(screen_height - 1)) begin
            y_pos      <= '0;
            frame_done <= 1'b1;
          end else begin
            y_pos <= y_pos + 1'b1;
          end
        end else begin
          x_pos <= x_pos + 1'b1;
          // first write of a new frame
          if (x_pos == '0 && y_pos == '0) begin
            frame_done <= 1'b0;
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_write) begin
      mem[wr_addr] <= shade;
    end
    rd_shade <= mem[rd_addr];
  end

  a_write_in_screen: assert property (@(posedge clk) disable iff (reset)
    do_write |-> (int'(x_pos) < screen_width) && (int'(y_pos) < screen_height)
                 && (int'(wr_addr) < num_pixels));

endmodule

`default_nettype wire

/* hw/pixel_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module pixel_fifo #(
  parameter int fifo_depth = 16,
  localparam int ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1,
  localparam int cnt_w = $clog2(fifo_depth + 1)
) (
  input  logic            clk,
  input  logic            reset,
  input  logic            row_valid,
  output logic            row_ready,
  input  logic [7:0]      row_lo,
  input  logic [7:0]      row_hi,
  input  logic            row_palette,
  output logic            pix_valid,
  output ppu_pkg::pixel_t pix,
  input  logic            pop
);

  ppu_pkg::pixel_t mem [fifo_depth];

  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;
  logic             accept;

  // Room for a whole row before taking it
  assign row_ready = (int'(count) + ppu_pkg::ROW_PIXELS) <= fifo_depth;
  assign accept    = row_valid && row_ready;

  // Head pixel is visible combinationally
  assign pix_valid = (count != '0);
  assign pix       = mem[rd_ptr];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (accept) begin
        wr_ptr <= ptr_w'((int'(wr_ptr) + ppu_pkg::ROW_PIXELS) % fifo_depth);
      end
      if (pop) begin
        rd_ptr <= ptr_w'((int'(rd_ptr) + 1) % fifo_depth);
      end
      case ({accept, pop})
        2'b10:   count <= count + cnt_w'(ppu_pkg::ROW_PIXELS);
        2'b11:   count <= count + cnt_w'(ppu_pkg::ROW_PIXELS - 1);
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Leftmost pixel is bit 7, hi plane gives the upper color bit
  always_ff @(posedge clk) begin
    if (accept) begin
      for (int i = 0; i < ppu_pkg::ROW_PIXELS; i++) begin
        mem[(int'(wr_ptr) + i) % fifo_depth] <= '{
          pal:   row_palette,
          color: {row_hi[ppu_pkg::ROW_PIXELS-1-i], row_lo[ppu_pkg::ROW_PIXELS-1-i]}
        };
      end
    end
  end

  a_count_bound: assert property (@(posedge clk) disable iff (reset)
    int'(count) <= fifo_depth);

  a_no_pop_empty: assert property (@(posedge clk) disable iff (reset)
    pop |-> pix_valid);

endmodule

`default_nettype wire

/* hw/pixel_mixer.sv */
`timescale 1ns/1ps
`default_nettype none

module pixel_mixer #(
  parameter int num_layers = 2
) (
  input  logic                             clk,
  input  logic                             reset,
  input  logic [num_layers-1:0]            lane_pix_valid,
  input  ppu_pkg::pixel_t [num_layers-1:0] lane_pix,
  output logic                             lane_pix_pop,
  input  logic [7:0]                       pal0,
  input  logic [7:0]                       pal1,
  output logic                             shade_valid,
  output ppu_pkg::shade_t                  shade,
  input  logic                             shade_ready
);

  ppu_pkg::color_t win_color;
  logic            win_pal;
  logic [7:0]      pal_byte;
  ppu_pkg::shade_t next_shade;

  // Every lane must have a pixel and the output slot must be free
  assign lane_pix_pop = (&lane_pix_valid) && (!shade_valid || shade_ready);

  // Highest layer with a nonzero color wins, layer 0 otherwise
  always_comb begin
    win_color = lane_pix[0].color;
    win_pal   = lane_pix[0].pal;
    for (int k = 1; k < num_layers; k++) begin
      if (lane_pix[k].color != 2'd0) begin
        win_color = lane_pix[k].color;
        win_pal   = lane_pix[k].pal;
      end
    end
  end

  assign pal_byte   = win_pal ? pal1 : pal0;
  assign next_shade = pal_byte[2*win_color +: 2];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      shade_valid <= 1'b0;
    end else if (lane_pix_pop) begin
      shade_valid <= 1'b1;
    end else if (shade_ready) begin
      shade_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (lane_pix_pop) begin
      shade <= next_shade;
    end
  end

  a_shade_hold: assert property (@(posedge clk) disable iff (reset)
    shade_valid && !shade_ready |=> shade_valid && $stable(shade));

endmodule

`default_nettype wire

/* hw/ppu_pixel_path.sv */
`timescale 1ns/1ps
`default_nettype none

module ppu_pixel_path #(
  parameter int screen_width  = ppu_pkg::DEFAULT_SCREEN_WIDTH,
  parameter int screen_height = ppu_pkg::DEFAULT_SCREEN_HEIGHT,
  parameter int num_layers    = ppu_pkg::DEFAULT_NUM_LAYERS,
  parameter int fifo_depth    = ppu_pkg::DEFAULT_FIFO_DEPTH,
  localparam int layer_w = (num_layers > 1) ? $clog2(num_layers) : 1,
  localparam int num_pixels = screen_width * screen_height,
  localparam int addr_w = (num_pixels > 1) ? $clog2(num_pixels) : 1
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               dot_en,
  input  logic               flush,
  input  logic [7:0]         scx,
  input  logic [7:0]         pal0,
  input  logic [7:0]         pal1,
  input  logic               row_valid,
  output logic               row_ready,
  input  logic [layer_w-1:0] row_layer,
  input  logic [7:0]         row_lo,
  input  logic [7:0]         row_hi,
  input  logic               row_palette,
  input  logic [addr_w-1:0]  rd_addr,
  output ppu_pkg::shade_t    rd_shade,
  output logic               frame_done
);

  logic [num_layers-1:0]            lane_row_valid;
  logic [num_layers-1:0]            lane_row_ready;
  logic [num_layers-1:0][7:0]       lane_row_lo;
  logic [num_layers-1:0][7:0]       lane_row_hi;
  logic [num_layers-1:0]            lane_row_palette;
  logic [num_layers-1:0]            lane_pix_valid;
  ppu_pkg::pixel_t [num_layers-1:0] lane_pix;
  logic                             lane_pix_pop;
  logic                             shade_valid;
  ppu_pkg::shade_t                  shade;
  logic                             shade_ready;

  row_dispatcher #(
    .num_layers(num_layers)
  ) i_row_dispatcher (
    .clk             (clk),
    .reset           (reset),
    .row_valid       (row_valid),
    .row_ready       (row_ready),
    .row_layer       (row_layer),
    .row_lo          (row_lo),
    .row_hi          (row_hi),
    .row_palette     (row_palette),
    .lane_row_valid  (lane_row_valid),
    .lane_row_ready  (lane_row_ready),
    .lane_row_lo     (lane_row_lo),
    .lane_row_hi     (lane_row_hi),
    .lane_row_palette(lane_row_palette)
  );

  // One queue per layer, all popped together by the mixer
  for (genvar k = 0; k < num_layers; k++) begin : g_lane
    pixel_fifo #(
      .fifo_depth(fifo_depth)
    ) i_pixel_fifo (
      .clk        (clk),
      .reset      (reset),
      .row_valid  (lane_row_valid[k]),
      .row_ready  (lane_row_ready[k]),
      .row_lo     (lane_row_lo[k]),
      .row_hi     (lane_row_hi[k]),
      .row_palette(lane_row_palette[k]),
      .pix_valid  (lane_pix_valid[k]),
      .pix        (lane_pix[k]),
      .pop        (lane_pix_pop)
    );
  end

  pixel_mixer #(
    .num_layers(num_layers)
  ) i_pixel_mixer (
    .clk           (clk),
    .reset         (reset),
    .lane_pix_valid(lane_pix_valid),
    .lane_pix      (lane_pix),
    .lane_pix_pop  (lane_pix_pop),
    .pal0          (pal0),
    .pal1          (pal1),
    .shade_valid   (shade_valid),
    .shade         (shade),
    .shade_ready   (shade_ready)
  );

  framebuffer #(
    .screen_width (screen_width),
    .screen_height(screen_height)
  ) i_framebuffer (
    .clk        (clk),
    .reset      (reset),
    .dot_en     (dot_en),
    .flush      (flush),
    .scx        (scx),
    .shade_valid(shade_valid),
    .shade      (shade),
    .shade_ready(shade_ready),
    .frame_done (frame_done),
    .rd_addr    (rd_addr),
    .rd_shade   (rd_shade)
  );

endmodule

`default_nettype wire

/* hw/ppu_pkg.sv */
`default_nettype none

package ppu_pkg;

  // Two-bit color index, 0 is transparent on the object layer
  typedef logic [1:0] color_t;

  // Pixel as it sits in a lane queue
  typedef struct packed {
    logic   pal;
    color_t color;
  } pixel_t;

  // Final grey level after the palette
  typedef logic [1:0] shade_t;

  // One decoded tile row is always 8 pixels wide
  localparam int ROW_PIXELS = 8;

  // Small screen, enough to exercise scroll and frame wrap
  localparam int DEFAULT_SCREEN_WIDTH  = 16;
  localparam int DEFAULT_SCREEN_HEIGHT = 4;

  // Background and object layers
  localparam int DEFAULT_NUM_LAYERS = 2;
  localparam int DEFAULT_FIFO_DEPTH = 16;

endpackage

`default_nettype wire

/* hw/row_dispatcher.sv */
`timescale 1ns/1ps
`default_nettype none

module row_dispatcher #(
  parameter int num_layers = 2,
  localparam int layer_w = (num_layers > 1) ? $clog2(num_layers) : 1
) (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          row_valid,
  output logic                          row_ready,
  input  logic [layer_w-1:0]            row_layer,
  input  logic [7:0]                    row_lo,
  input  logic [7:0]                    row_hi,
  input  logic                          row_palette,
  output logic [num_layers-1:0]         lane_row_valid,
  input  logic [num_layers-1:0]         lane_row_ready,
  output logic [num_layers-1:0][7:0]    lane_row_lo,
  output logic [num_layers-1:0][7:0]    lane_row_hi,
  output logic [num_layers-1:0]         lane_row_palette
);

  logic               hold_valid;
  logic [layer_w-1:0] hold_layer;
  logic [7:0]         hold_lo;
  logic [7:0]         hold_hi;
  logic               hold_palette;
  logic               hold_taken;
  logic               row_accept;

  // Only the lane named by the held layer sees valid
  always_comb begin
    hold_taken = 1'b0;
    for (int k = 0; k < num_layers; k++) begin
      lane_row_valid[k]   = hold_valid && (hold_layer == layer_w'(k));
      lane_row_lo[k]      = hold_lo;
      lane_row_hi[k]      = hold_hi;
      lane_row_palette[k] = hold_palette;
      if (lane_row_valid[k] && lane_row_ready[k]) begin
        hold_taken = 1'b1;
      end
    end
  end

  // Free now, or freed by the lane on this edge
  assign row_ready  = !hold_valid || hold_taken;
  assign row_accept = row_valid && row_ready;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      hold_valid <= 1'b0;
    end else if (row_accept) begin
      hold_valid <= 1'b1;
    end else if (hold_taken) begin
      hold_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (row_accept) begin
      hold_layer   <= row_layer;
      hold_lo      <= row_lo;
      hold_hi      <= row_hi;
      hold_palette <= row_palette;
    end
  end

  a_layer_in_range: assert property (@(posedge clk) disable iff (reset)
    row_accept |-> (int'(row_layer) < num_layers));

endmodule

`default_nettype wire

/* ppu_pixel_path.f */
hw/ppu_pkg.sv
hw/row_dispatcher.sv
hw/pixel_fifo.sv
hw/pixel_mixer.sv
hw/framebuffer.sv
hw/ppu_pixel_path.sv
verif/ppu_pixel_path_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run with Verilator, the exit status follows the testbench verdict
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module ppu_pixel_path_tb \
  -f ppu_pixel_path.f -o ppu_pixel_path_sim &&
./obj_dir/ppu_pixel_path_sim | tee /dev/stderr | grep "sim passed" > /dev/null &&
echo "run_sim: simulation reported a pass" ||
{ echo "run_sim: simulation did not report a pass"; exit 1; }

/* verif/ppu_pixel_path_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module ppu_pixel_path_tb;

  localparam int screen_width  = ppu_pkg::DEFAULT_SCREEN_WIDTH;
  localparam int screen_height = ppu_pkg::DEFAULT_SCREEN_HEIGHT;
  localparam int num_pixels    = screen_width * screen_height;
  localparam int addr_w        = $clog2(num_pixels);
  localparam int clk_period    = 40;
  localparam int drive_delay   = 2;
  localparam int num_tests     = 6;
  // Longest frame keeps 7 scroll pixels per line
  localparam int frame_cycles  = (screen_width + 8) * screen_height;
  localparam int timeout_ns    = num_tests * frame_cycles * 24 * clk_period;

  logic              clk = 1'b0;
  logic              reset;
  logic              dot_en;
  logic              flush;
  logic [7:0]        scx;
  logic [7:0]        pal0;
  logic [7:0]        pal1;
  logic              row_valid;
  logic              row_ready;
  logic [0:0]        row_layer;
  logic [7:0]        row_lo;
  logic [7:0]        row_hi;
  logic              row_palette;
  logic [addr_w-1:0] rd_addr;
  ppu_pkg::shade_t   rd_shade;
  logic              frame_done;

  // Model pixel streams per layer and the expected screen
  ppu_pkg::pixel_t bg_q[$];
  ppu_pkg::pixel_t obj_q[$];
  ppu_pkg::shade_t exp_mem [num_pixels];
  int              mx;
  int              my;
  int              skip_left;
  bit              line_open;
  bit              exp_done;
  logic [31:0]     data_state;
  logic [31:0]     stall_state;
  bit              stream_busy;
  int              test_errors;
  int              total_errors;
  int              failed_tests;
  int              tests_run;

  ppu_pixel_path #(
    .screen_width (screen_width),
    .screen_height(screen_height),
    .num_layers   (ppu_pkg::DEFAULT_NUM_LAYERS),
    .fifo_depth   (ppu_pkg::DEFAULT_FIFO_DEPTH)
  ) i_ppu_pixel_path (
    .clk        (clk),
    .reset      (reset),
    .dot_en     (dot_en),
    .flush      (flush),
    .scx        (scx),
    .pal0       (pal0),
    .pal1       (pal1),
    .row_valid  (row_valid),
    .row_ready  (row_ready),
    .row_layer  (row_layer),
    .row_lo     (row_lo),
    .row_hi     (row_hi),
    .row_palette(row_palette),
    .rd_addr    (rd_addr),
    .rd_shade   (rd_shade),
    .frame_done (frame_done)
  );

  always #(clk_period / 2) clk = ~clk;

  function automatic logic [31:0] lcg(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [7:0] rand_byte();
    data_state = lcg(data_state);
    return data_state[31:24];
  endfunction

  function automatic ppu_pkg::shade_t palette_shade(input logic [7:0] pal,
                                                    input ppu_pkg::color_t color);
    case (color)
      2'd0:    return pal[1:0];
      2'd1:    return pal[3:2];
      2'd2:    return pal[5:4];
      default: return pal[7:6];
    endcase
  endfunction

  // Object shows unless transparent
  function automatic ppu_pkg::shade_t expected_shade(input ppu_pkg::pixel_t bg,
                                                     input ppu_pkg::pixel_t obj);
    ppu_pkg::pixel_t win;
    win = (obj.color != 2'd0) ? obj : bg;
    return palette_shade(win.pal ? pal1 : pal0, win.color);
  endfunction

  task automatic model_consume(input int n);
    ppu_pkg::pixel_t bg;
    ppu_pkg::pixel_t obj;
    for (int i = 0; i < n; i++) begin
      bg  = bg_q.pop_front();
      obj = obj_q.pop_front();
      if (!line_open) begin
        line_open = 1'b1;
        skip_left = int'(scx[2:0]);
      end
      if (skip_left > 0) begin
        skip_left--;
      end else begin
        if (mx == 0 && my == 0) begin
          exp_done = 1'b0;
        end
        exp_mem[my * screen_width + mx] = expected_shade(bg, obj);
        mx++;
        if (mx == screen_width) begin
          mx        = 0;
          my++;
          line_open = 1'b0;
          if (my == screen_height) begin
            my       = 0;
            exp_done = 1'b1;
          end
        end
      end
    end
  endtask

  task automatic model_flush();
    mx        = 0;
    my        = 0;
    skip_left = 0;
    line_open = 1'b0;
    exp_done  = 1'b0;
  endtask

  task automatic send_row(input bit layer, input logic [7:0] lo, input logic [7:0] hi,
                          input bit pal);
    bit              taken;
    ppu_pkg::pixel_t p;
    row_valid   = 1'b1;
    row_layer   = layer;
    row_lo      = lo;
    row_hi      = hi;
    row_palette = pal;
    taken       = 1'b0;
    while (!taken) begin
      // Ready only moves on clock edges
      @(negedge clk);
      taken = row_ready;
      @(posedge clk);
      #drive_delay;
    end
    row_valid = 1'b0;
    for (int i = 7; i >= 0; i--) begin
      p.pal   = pal;
      p.color = {hi[i], lo[i]};
      if (layer) begin
        obj_q.push_back(p);
      end else begin
        bg_q.push_back(p);
      end
    end
  endtask

  // Background and object rows alternate so both lanes keep flowing
  task automatic stream_pairs(input int pairs, input bit with_obj, input bit bg_pal);
    logic [7:0] sel;
    logic [7:0] lo;
    logic [7:0] hi;
    for (int n = 0; n < pairs; n++) begin
      sel = rand_byte();
      lo  = rand_byte();
      hi  = rand_byte();
      send_row(1'b0, lo, hi, bg_pal & sel[0]);
      lo  = with_obj ? rand_byte() : 8'h00;
      hi  = with_obj ? rand_byte() : 8'h00;
      send_row(1'b1, lo, hi, sel[1]);
    end
  endtask

  task automatic wait_frame_done();
    while (frame_done !== 1'b1) begin
      @(posedge clk);
      #drive_delay;
    end
  endtask

  task automatic pulse_dots(input int n);
    dot_en = 1'b1;
    repeat (n) begin
      @(posedge clk);
      #drive_delay;
    end
    dot_en = 1'b0;
  endtask

  task automatic pulse_flush();
    flush = 1'b1;
    @(posedge clk);
    #drive_delay;
    flush = 1'b0;
    model_flush();
  endtask

  task automatic check_flag();
    assert (frame_done === exp_done) else begin
      $display("[ERROR] %0d ns: frame_done is %b, expected %b", $time, frame_done, exp_done);
      test_errors++;
    end
  endtask

  task automatic check_image(input int count);
    for (int a = 0; a < count; a++) begin
      rd_addr = addr_w'(a);
      @(posedge clk);
      #drive_delay;
      assert (rd_shade === exp_mem[a]) else begin
        $display("[ERROR] %0d ns: address %0d holds shade %0d, expected %0d",
                 $time, a, rd_shade, exp_mem[a]);
        test_errors++;
      end
    end
  endtask

  task automatic check_frame();
    model_consume(bg_q.size());
    check_flag();
    check_image(num_pixels);
  endtask

  task automatic run_frames(input int pairs, input bit with_obj, input bit bg_pal);
    stream_pairs(pairs, with_obj, bg_pal);
    wait_frame_done();
    check_frame();
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (test_errors == 0) begin
      $display("Test %0d %s: ok", tests_run, name);
    end else begin
      $display("Test %0d %s: %0d errors", tests_run, name, test_errors);
      failed_tests++;
    end
    total_errors += test_errors;
    test_errors = 0;
  endtask

  task automatic test_bg_only();
    assert (row_ready === 1'b1 && frame_done === 1'b0) else begin
      $display("[ERROR] %0d ns: after reset row_ready is %b and frame_done is %b",
               $time, row_ready, frame_done);
      test_errors++;
    end
    pal0   = 8'h9c;
    pal1   = 8'h1b;
    dot_en = 1'b1;
    run_frames(8, 1'b0, 1'b0);
    finish_test("bg_only");
  endtask

  // Every color maps to a different shade in pal1 than in pal0
  task automatic test_obj_override();
    pal1 = 8'h39;
    run_frames(8, 1'b1, 1'b0);
    finish_test("obj_override");
  endtask

  // 19 row pairs make exactly two frames of 76 pixels
  task automatic test_scroll();
    scx = 8'd3;
    run_frames(19, 1'b1, 1'b1);
    scx = 8'd0;
    finish_test("scroll");
  endtask

  task automatic test_stall();
    int hold;
    stream_busy = 1'b1;
    fork
      begin
        stream_pairs(8, 1'b1, 1'b1);
        wait_frame_done();
        stream_busy = 1'b0;
      end
      begin
        while (stream_busy) begin
          stall_state = lcg(stall_state);
          dot_en      = ~dot_en;
          hold        = 1 + int'(stall_state[31:29]);
          repeat (hold) begin
            @(posedge clk);
            #drive_delay;
          end
        end
        dot_en = 1'b1;
      end
    join
    check_frame();
    finish_test("stall");
  endtask

  task automatic test_flush();
    dot_en = 1'b0;
    stream_pairs(2, 1'b1, 1'b1);
    // Dispatcher, lane and mixer register each take one cycle
    repeat (3) begin
      @(posedge clk);
      #drive_delay;
    end
    pulse_dots(1);
    model_consume(1);
    check_flag();
    pulse_dots(7);
    model_consume(7);
    check_image(8);
    pulse_flush();
    check_flag();
    // Eight held pixels plus seven pairs refill the screen from address 0
    dot_en = 1'b1;
    run_frames(7, 1'b1, 1'b1);
    pulse_flush();
    check_flag();
    finish_test("flush");
  endtask

  task automatic test_random_frames();
    for (int f = 0; f < 2; f++) begin
      pal0 = rand_byte();
      pal1 = rand_byte();
      run_frames(8, 1'b1, 1'b1);
    end
    finish_test("random_frames");
  endtask

  initial begin
    reset        = 1'b1;
    dot_en       = 1'b0;
    flush        = 1'b0;
    scx          = 8'd0;
    pal0         = 8'd0;
    pal1         = 8'd0;
    row_valid    = 1'b0;
    row_layer    = 1'b0;
    row_lo       = 8'd0;
    row_hi       = 8'd0;
    row_palette  = 1'b0;
    rd_addr      = '0;
    data_state   = 32'd80482;
    stall_state  = lcg(32'd80482);
    stream_busy  = 1'b0;
    test_errors  = 0;
    total_errors = 0;
    failed_tests = 0;
    tests_run    = 0;
    model_flush();
    repeat (2) @(posedge clk);
    #drive_delay;
    reset = 1'b0;
    test_bg_only();
    test_obj_override();
    test_scroll();
    test_stall();
    test_flush();
    test_random_frames();
    $display("Summary: %0d tests run, %0d with errors, %0d failed checks",
             tests_run, failed_tests, total_errors);
    if (total_errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(timeout_ns);
    $display("Timeout: the tests did not finish within %0d ns", timeout_ns);
    $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire
